/* Makefile */
# Verilator build and run for the de-quantization pipeline

VERILATOR ?= verilator
TOP       ?= tb_dequant_top
FLIST     ?= dequant.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dequant.f */
design/dequant_pkg.sv
design/bf16_res_if.sv
design/dq_decode.sv
design/leading_zero_count.sv
design/int_to_bf16_execute.sv
design/dq_result.sv
design/dequant_top.sv
sim/tb_dequant_top.sv

/* design/bf16_res_if.sv */
// Carries one converted BF16 result from the execute stage to the result stage

`default_nettype none
`timescale 1ns/1ps

interface bf16_res_if;
    import dequant_pkg::*;

    // One-cycle strobe per item
    logic                  valid;
    // Fields below only meaningful while valid is high
    logic [BF16_WIDTH-1:0] bf16;
    logic                  is_zero;
    logic                  inexact;

    // Execute side drives everything
    modport producer (
        output valid,
        output bf16,
        output is_zero,
        output inexact
    );

    // Result side only samples
    modport consumer (
        input valid,
        input bf16,
        input is_zero,
        input inexact
    );

endinterface : bf16_res_if

`default_nettype wire

/* design/dequant_pkg.sv */
// Shared widths, BF16 field constants and opcodes for the de-quantization pipeline

`default_nettype none

package dequant_pkg;

    // ------------------------------
    // Integer side
    // ------------------------------

    // Accumulator word width, fixed for the whole unit
    localparam int INT_WIDTH = 32;

    // Leading-zero count must hold 0..32
    localparam int LZC_WIDTH = 6;

    // ------------------------------
    // BF16 format
    // ------------------------------

    // sign[15], exp[14:7], mant[6:0]
    localparam int BF16_WIDTH     = 16;
    localparam int BF16_EXP_BITS  = 8;
    localparam int BF16_MANT_BITS = 7;
    localparam int BF16_EXP_BIAS  = 127;

    // Reserved exponent code for inf and NaN
    localparam int BF16_EXP_MAX = 255;

    // Exponent of a leading one at the top integer bit
    localparam int INT_EXP_BASE = BF16_EXP_BIAS + INT_WIDTH - 1;

    // ------------------------------
    // Opcodes
    // ------------------------------

    typedef enum logic [1:0] {
        // Value as it is
        OP_CONVERT = 2'b00,
        // Negative values become zero
        OP_RELU    = 2'b01,
        // Absolute value
        OP_ABS     = 2'b10,
        // Negated value
        OP_NEGATE  = 2'b11
    } dq_opcode_e;

endpackage : dequant_pkg

`default_nettype wire

/* design/dequant_top.sv */
// Top level of the INT32 to BF16 de-quantization pipeline, decode then execute then result

`default_nettype none
`timescale 1ns/1ps

module dequant_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     in_valid,
    input  dequant_pkg::dq_opcode_e                  in_opcode,
    input  logic signed [dequant_pkg::INT_WIDTH-1:0] in_data,
    input  logic                                     status_clear,
    output logic                                     out_valid,
    output logic [dequant_pkg::BF16_WIDTH-1:0]       out_bf16,
    output logic                                     out_is_zero,
    output logic                                     out_inexact,
    output logic                                     inexact_seen
);
    import dequant_pkg::*;

    // Decode to execute
    logic                 dec_valid;
    logic                 dec_sign;
    logic [INT_WIDTH-1:0] dec_magnitude;

    // Execute to result
    bf16_res_if res_if ();

    // ------------------------------
    // Pipeline stages
    // ------------------------------

    dq_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_opcode     (in_opcode),
        .in_data       (in_data),
        .dec_valid     (dec_valid),
        .dec_sign      (dec_sign),
        .dec_magnitude (dec_magnitude)
    );

    int_to_bf16_execute u_execute (
        .clk           (clk),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_sign      (dec_sign),
        .dec_magnitude (dec_magnitude),
        .res           (res_if.producer)
    );

    dq_result u_result (
        .clk          (clk),
        .reset        (reset),
        .res          (res_if.consumer),
        .status_clear (status_clear),
        .out_valid    (out_valid),
        .out_is_zero  (out_is_zero),
        .out_inexact  (out_inexact),
        .out_bf16     (out_bf16),
        .inexact_seen (inexact_seen)
    );

endmodule : dequant_top

`default_nettype wire

/* design/dq_decode.sv */
// Decode stage, registers the input and turns opcode plus integer into sign and magnitude

`default_nettype none
`timescale 1ns/1ps

module dq_decode (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    input  dequant_pkg::dq_opcode_e               in_opcode,
    input  logic signed [dequant_pkg::INT_WIDTH-1:0] in_data,
    output logic                                  dec_valid,
    output logic                                  dec_sign,
    output logic [dequant_pkg::INT_WIDTH-1:0]     dec_magnitude
);
    import dequant_pkg::*;

    logic                 in_neg;
    logic [INT_WIDTH-1:0] in_abs;
    logic                 next_sign;
    logic [INT_WIDTH-1:0] next_mag;

    // ------------------------------
    // Sign and magnitude
    // ------------------------------

    // Two's complement absolute value
    // The most negative word maps to 2^31, which still fits unsigned
    assign in_neg = in_data[INT_WIDTH-1];
    assign in_abs = in_neg ? (~in_data + 1'b1) : in_data;

    always_comb begin
        next_sign = in_neg;
        next_mag  = in_abs;
        case (in_opcode)
            OP_CONVERT: begin
                next_sign = in_neg;
                next_mag  = in_abs;
            end
            OP_RELU: begin
                // Clamp negatives to zero
                next_sign = 1'b0;
                next_mag  = in_neg ? '0 : in_abs;
            end
            OP_ABS: begin
                next_sign = 1'b0;
                next_mag  = in_abs;
            end
            OP_NEGATE: begin
                next_sign = ~in_neg;
                next_mag  = in_abs;
            end
        endcase
        // Zero is always +0.0
        if (next_mag == '0) begin
            next_sign = 1'b0;
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Payload, only qualified by dec_valid
    always_ff @(posedge clk) begin
        dec_sign      <= next_sign;
        dec_magnitude <= next_mag;
    end

    // No negative zero may leave decode
    a_no_neg_zero : assert property (
        @(posedge clk) disable iff (reset)
        dec_valid |-> !(dec_sign && (dec_magnitude == '0))
    ) else $error("dq_decode: negative zero on decode output");

endmodule : dq_decode

`default_nettype wire

/* design/dq_result.sv */
// Result stage, drives the output ports and keeps the sticky inexact status

`default_nettype none
`timescale 1ns/1ps

module dq_result (
    input  logic                               clk,
    input  logic                               reset,
    bf16_res_if.consumer                       res,
    input  logic                               status_clear,
    output logic                               out_valid,
    output logic                               out_is_zero,
    output logic                               out_inexact,
    output logic [dequant_pkg::BF16_WIDTH-1:0] out_bf16,
    output logic                               inexact_seen
);
    import dequant_pkg::*;

    // ------------------------------
    // Output registers
    // ------------------------------

    // Strobe follows the interface one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= res.valid;
        end
    end

    // Fields hold their last value between items
    always_ff @(posedge clk) begin
        if (res.valid) begin
            out_bf16    <= res.bf16;
            out_is_zero <= res.is_zero;
            out_inexact <= res.inexact;
        end
    end

    // ------------------------------
    // Sticky status
    // ------------------------------

    // A new inexact result wins over a clear on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            inexact_seen <= 1'b0;
        end else if (out_valid && out_inexact) begin
            inexact_seen <= 1'b1;
        end else if (status_clear) begin
            inexact_seen <= 1'b0;
        end
    end

    // Zero flag and word agree
    a_zero_word : assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && out_is_zero) |-> (out_bf16 == '0)
    ) else $error("dq_result: zero flag with nonzero word");

endmodule : dq_result

`default_nettype wire

/* design/int_to_bf16_execute.sv */
// Execute stage, normalizes the magnitude, rounds to nearest-even and registers the BF16 word

`default_nettype none
`timescale 1ns/1ps

module int_to_bf16_execute (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              dec_valid,
    input  logic                              dec_sign,
    input  logic [dequant_pkg::INT_WIDTH-1:0] dec_magnitude,
    bf16_res_if.producer                      res
);
    import dequant_pkg::*;

    // Bit positions inside the normalized word
    localparam int MANT_TOP  = INT_WIDTH - 2;
    localparam int MANT_BOT  = INT_WIDTH - 1 - BF16_MANT_BITS;
    localparam int GUARD_POS = MANT_BOT - 1;

    logic [LZC_WIDTH-1:0]      lzc;
    logic [INT_WIDTH-1:0]      normalized;
    logic [BF16_MANT_BITS-1:0] mant_raw;
    logic                      guard;
    logic                      sticky;
    logic                      round_up;
    logic [BF16_MANT_BITS:0]   mant_rounded;
    logic                      mant_carry;
    logic [BF16_EXP_BITS-1:0]  exp_raw;
    logic [BF16_EXP_BITS-1:0]  exp_final;
    logic                      mag_zero;
    logic [BF16_WIDTH-1:0]     bf16_next;
    logic                      inexact_next;

    // ------------------------------
    // Normalize
    // ------------------------------

    leading_zero_count u_lzc (
        .data  (dec_magnitude),
        .count (lzc)
    );

    // Leading one ends up at the top bit
    assign normalized = dec_magnitude << lzc;
    assign mag_zero   = (dec_magnitude == '0);

    // Position of leading one is 31 - lzc
    // Exponent therefore 158 - lzc, never above 158 before carry
    assign exp_raw = BF16_EXP_BITS'(INT_EXP_BASE) - {{(BF16_EXP_BITS-LZC_WIDTH){1'b0}}, lzc};

    // ------------------------------
    // RNE rounding
    // ------------------------------

    // 7 bits right below the hidden one
    assign mant_raw = normalized[MANT_TOP:MANT_BOT];
    assign guard    = normalized[GUARD_POS];
    // Round bit folded into sticky
    assign sticky   = |normalized[GUARD_POS-1:0];

    // Above half, or exact tie with odd LSB
    assign round_up = guard & (sticky | mant_raw[0]);

    assign mant_rounded = {1'b0, mant_raw} + {{BF16_MANT_BITS{1'b0}}, round_up};
    // 0x7F + 1 wraps the stored field to zero and bumps the exponent
    assign mant_carry   = mant_rounded[BF16_MANT_BITS];
    assign exp_final    = exp_raw + {{(BF16_EXP_BITS-1){1'b0}}, mant_carry};

    // Bits lost on the way
    assign inexact_next = guard | sticky;

    // Assemble the word, zero forces +0.0
    always_comb begin
        if (mag_zero) begin
            bf16_next = '0;
        end else begin
            bf16_next = {dec_sign, exp_final, mant_rounded[BF16_MANT_BITS-1:0]};
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        res.bf16    <= bf16_next;
        res.is_zero <= mag_zero;
        res.inexact <= inexact_next;
    end

    // Integers never produce zero/subnormal or inf/NaN exponents
    a_exp_in_range : assert property (
        @(posedge clk) disable iff (reset)
        (res.valid && !res.is_zero) |->
            (res.bf16[BF16_WIDTH-2:BF16_MANT_BITS] != '0) &&
            (res.bf16[BF16_WIDTH-2:BF16_MANT_BITS] != BF16_EXP_BITS'(BF16_EXP_MAX))
    ) else $error("int_to_bf16_execute: exponent out of normal range");

endmodule : int_to_bf16_execute

`default_nettype wire

/* design/leading_zero_count.sv */
// Combinational leading-zero counter for the 32-bit magnitude, all-zero gives 32

`default_nettype none
`timescale 1ns/1ps

module leading_zero_count (
    input  logic [dequant_pkg::INT_WIDTH-1:0] data,
    output logic [dequant_pkg::LZC_WIDTH-1:0] count
);
    import dequant_pkg::*;

    // Set once the first one is met
    logic found;

    // ------------------------------
    // Priority scan, MSB first
    // ------------------------------

    // Walks down from the top bit
    // First one seen fixes the count, later bits are ignored
    always_comb begin
        count = LZC_WIDTH'(INT_WIDTH);
        found = 1'b0;
        for (int i = INT_WIDTH - 1; i >= 0; i--) begin
            if (!found && data[i]) begin
                count = LZC_WIDTH'(INT_WIDTH - 1 - i);
                found = 1'b1;
            end
        end
    end

endmodule : leading_zero_count

`default_nettype wire

/* sim/tb_dequant_top.sv */
// Testbench for the INT32 to BF16 pipeline, built as top with the design from the file list

`default_nettype none
`timescale 1ns/1ps

module tb_dequant_top;
    import dequant_pkg::*;

    localparam int HALF_PERIOD  = 10;
    localparam int RANDOM_COUNT = 600;
    // Directed part plus random part comes to about 700 cycles
    localparam int MAX_CYCLES   = 2000;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    dq_opcode_e            in_opcode;
    logic signed [31:0]    in_data;
    logic                  status_clear;
    logic                  out_valid;
    logic [15:0]           out_bf16;
    logic                  out_is_zero;
    logic                  out_inexact;
    logic                  inexact_seen;

    // Expected {inexact, is_zero, word} delayed by the pipeline depth
    logic [2:0]            exp_valid;
    logic [17:0]           exp_res [3];
    logic [17:0]           ref_res;
    logic                  seen_model;
    logic signed [31:0]    rnd;
    int                    cycles = 0;
    integer                seed = 18958;
    string                 test_name = "reset";

    dequant_top UUT (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_opcode    (in_opcode),
        .in_data      (in_data),
        .status_clear (status_clear),
        .out_valid    (out_valid),
        .out_bf16     (out_bf16),
        .out_is_zero  (out_is_zero),
        .out_inexact  (out_inexact),
        .inexact_seen (inexact_seen)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    // ------------------------------
    // Reference pipeline
    // ------------------------------

    always @(posedge clk) begin
        if (reset) begin
            exp_valid  <= '0;
            seen_model <= 1'b0;
        end else begin
            exp_valid <= {exp_valid[1:0], in_valid};
            // Set on an inexact output beats a clear on the same edge
            if (exp_valid[2] && exp_res[2][17]) begin
                seen_model <= 1'b1;
            end else if (status_clear) begin
                seen_model <= 1'b0;
            end
        end
        exp_res[0] <= ref_res;
        exp_res[1] <= exp_res[0];
        exp_res[2] <= exp_res[1];
    end

    // Opcode rule on a wide signed value, then RNE on the leading one position
    function automatic logic [17:0] ref_convert(input dq_opcode_e op,
                                                input logic signed [31:0] data);
        longint     value;
        longint     mag;
        int         pos;
        int         expo;
        logic       neg;
        logic       guard;
        logic       sticky;
        logic [6:0] mant;
        value = longint'(data);
        case (op)
            OP_RELU:   if (value < 0) value = 0;
            OP_ABS:    if (value < 0) value = -value;
            OP_NEGATE: value = -value;
            default:   ;
        endcase
        neg = (value < 0);
        mag = neg ? -value : value;
        if (mag == 0) begin
            return {1'b0, 1'b1, 16'h0000};
        end
        pos = 0;
        for (int b = 0; b < 32; b++) begin
            if (mag[b]) pos = b;
        end
        if (pos >= 7) mant = 7'((mag >> (pos - 7)) & 64'h7F);
        else          mant = 7'((mag << (7 - pos)) & 64'h7F);
        guard  = (pos >= 8) ? mag[pos-8] : 1'b0;
        sticky = (pos >= 9) ? ((mag & ((longint'(1) << (pos - 8)) - 1)) != 0) : 1'b0;
        expo   = 127 + pos;
        if (guard && (sticky || mant[0])) begin
            // Full mantissa rolls over into the exponent
            if (mant == 7'h7F) expo++;
            mant = mant + 7'd1;
        end
        return {guard | sticky, 1'b0, neg, 8'(expo), mant};
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic fail_value(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("CHECK FAILED %s %s: expected 0x%0h actual 0x%0h",
                 test_name, field, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    // Strobe exactly three cycles after each accepted input
    a_out_valid : assert property (@(posedge clk) disable iff (reset)
        out_valid == exp_valid[2])
        else fail_value("out_valid", 32'($sampled(exp_valid[2])), 32'($sampled(out_valid)));

    // Packed as {inexact, is_zero, bf16}
    a_result : assert property (@(posedge clk) disable iff (reset)
        exp_valid[2] |-> ({out_inexact, out_is_zero, out_bf16} == exp_res[2]))
        else fail_value("result", 32'($sampled(exp_res[2])),
                        32'($sampled({out_inexact, out_is_zero, out_bf16})));

    a_seen : assert property (@(posedge clk) disable iff (reset)
        inexact_seen == seen_model)
        else fail_value("inexact_seen", 32'($sampled(seen_model)), 32'($sampled(inexact_seen)));

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    task automatic issue_res(input dq_opcode_e op, input logic signed [31:0] data,
                             input logic [17:0] res);
        in_valid  = 1'b1;
        in_opcode = op;
        in_data   = data;
        ref_res   = res;
        @(posedge clk);
        #2;
    endtask

    task automatic issue(input dq_opcode_e op, input logic signed [31:0] data);
        issue_res(op, data, ref_convert(op, data));
    endtask

    task automatic wait_output();
        in_valid = 1'b0;
        while (!out_valid) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic known(input dq_opcode_e op, input logic signed [31:0] data,
                         input logic [17:0] res);
        issue_res(op, data, res);
        wait_output();
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (exp_valid != '0) begin
            @(posedge clk);
            #2;
        end
        idle(1);
    endtask

    task automatic pulse_clear();
        status_clear = 1'b1;
        idle(1);
        status_clear = 1'b0;
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_opcode    = OP_CONVERT;
        in_data      = '0;
        status_clear = 1'b0;
        ref_res      = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        test_name = "known_values";
        known(OP_CONVERT, 1, 18'h03F80);
        known(OP_CONVERT, 127, 18'h042FE);
        known(OP_CONVERT, -128, 18'h0C300);
        known(OP_CONVERT, 0, 18'h10000);
        known(OP_CONVERT, 256, 18'h04380);
        known(OP_CONVERT, 32'sh8000_0000, 18'h0CF00);

        test_name = "opcode_rules";
        known(OP_RELU, -5, 18'h10000);
        known(OP_ABS, -5, 18'h040A0);
        known(OP_CONVERT, 5, 18'h040A0);
        known(OP_NEGATE, 5, 18'h0C0A0);
        known(OP_NEGATE, 0, 18'h10000);

        // Ties go to even, 0x1FF carries up to 512.0
        test_name = "rounding";
        known(OP_CONVERT, 257, 18'h24380);
        known(OP_CONVERT, 259, 18'h24382);
        known(OP_CONVERT, 32'h1FF, 18'h24400);
        pulse_clear();

        // Bursts with gaps of 1 to 3 cycles
        test_name = "latency_strobes";
        for (int g = 1; g <= 3; g++) begin
            for (int i = 0; i < 4 - g; i++) issue(OP_CONVERT, 32'(100 * g + i));
            idle(g);
        end
        drain();

        test_name = "sticky_status";
        pulse_clear();
        single_exact: begin
            issue(OP_CONVERT, 1);
            issue(OP_ABS, -128);
            drain();
        end
        issue(OP_CONVERT, 257);
        drain();
        pulse_clear();
        idle(1);
        // Clear lands on the same edge as the next inexact output
        issue(OP_CONVERT, 259);
        wait_output();
        pulse_clear();
        idle(2);

        test_name = "random_operands";
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            rnd = $random(seed);
            // Some smaller operands so exact results show up too
            if (k % 4 == 1) rnd = rnd >>> ($random(seed) & 31);
            issue(dq_opcode_e'(2'($random(seed))), rnd);
        end
        drain();

        $display("Test passed");
        $finish;
    end

endmodule : tb_dequant_top

`default_nettype wire
